//--- verilog/lbist_macros.svh
`ifndef LBIST_MACROS_SVH
`define LBIST_MACROS_SVH

// Pattern generator widths and pattern count width
`define LBIST_A_BITS   16
`define LBIST_B_BITS   8
`define LBIST_CNT_BITS 10

// ==============================
// LFSR tap table, widths 2 to 44 and 64
// ==============================

// Widths the tap table covers
`define LBIST_WIDTH_OK(w) ((((w) >= 2) && ((w) <= 44)) || ((w) == 64))

// Widths using four taps and XNOR feedback, all others use two taps and XOR
`define LBIST_FOUR_TAP(w) ( \
    (w)==8  || (w)==12 || (w)==13 || (w)==14 || (w)==16 || (w)==19 || (w)==24 || (w)==26 || \
    (w)==27 || (w)==30 || (w)==32 || (w)==34 || (w)==37 || (w)==38 || (w)==40 || (w)==64)

`define LBIST_TAP1(w) ( \
    (w)==2  ?  0 : (w)==3  ?  1 : (w)==4  ?  2 : (w)==5  ?  2 : (w)==6  ?  4 : (w)==7  ?  5 : \
    (w)==8  ?  3 : (w)==9  ?  4 : (w)==10 ?  6 : (w)==11 ?  8 : (w)==12 ?  5 : (w)==13 ?  8 : \
    (w)==14 ?  8 : (w)==15 ? 13 : (w)==16 ? 10 : (w)==17 ? 13 : (w)==18 ? 10 : (w)==19 ? 13 : \
    (w)==20 ? 16 : (w)==21 ? 18 : (w)==22 ? 20 : (w)==23 ? 17 : (w)==24 ? 19 : (w)==25 ? 21 : \
    (w)==26 ? 19 : (w)==27 ? 21 : (w)==28 ? 24 : (w)==29 ? 26 : (w)==30 ? 23 : (w)==31 ? 27 : \
    (w)==32 ? 25 : (w)==33 ? 18 : (w)==34 ? 24 : (w)==35 ? 32 : (w)==36 ? 25 : (w)==37 ? 30 : \
    (w)==38 ? 31 : (w)==39 ? 34 : (w)==40 ? 35 : (w)==41 ? 37 : (w)==42 ? 38 : (w)==43 ? 40 : \
    (w)==44 ? 39 : (w)==64 ? 59 : 0)

`define LBIST_TAP2(w) ( \
    (w)==2  ?  1 : (w)==3  ?  2 : (w)==4  ?  3 : (w)==5  ?  4 : (w)==6  ?  5 : (w)==7  ?  6 : \
    (w)==8  ?  4 : (w)==9  ?  8 : (w)==10 ?  9 : (w)==11 ? 10 : (w)==12 ?  7 : (w)==13 ?  9 : \
    (w)==14 ? 10 : (w)==15 ? 14 : (w)==16 ? 12 : (w)==17 ? 16 : (w)==18 ? 17 : (w)==19 ? 16 : \
    (w)==20 ? 19 : (w)==21 ? 20 : (w)==22 ? 21 : (w)==23 ? 22 : (w)==24 ? 20 : (w)==25 ? 24 : \
    (w)==26 ? 20 : (w)==27 ? 22 : (w)==28 ? 27 : (w)==29 ? 28 : (w)==30 ? 25 : (w)==31 ? 30 : \
    (w)==32 ? 26 : (w)==33 ? 32 : (w)==34 ? 28 : (w)==35 ? 34 : (w)==36 ? 35 : (w)==37 ? 32 : \
    (w)==38 ? 34 : (w)==39 ? 38 : (w)==40 ? 37 : (w)==41 ? 40 : (w)==42 ? 41 : (w)==43 ? 42 : \
    (w)==44 ? 43 : (w)==64 ? 60 : 0)

// Third and fourth taps exist only for the four-tap widths
`define LBIST_TAP3(w) ( \
    (w)==8  ?  5 : (w)==12 ? 10 : (w)==13 ? 11 : (w)==14 ? 12 : (w)==16 ? 13 : (w)==19 ? 17 : \
    (w)==24 ? 22 : (w)==26 ? 24 : (w)==27 ? 24 : (w)==30 ? 27 : (w)==32 ? 29 : (w)==34 ? 29 : \
    (w)==37 ? 33 : (w)==38 ? 36 : (w)==40 ? 38 : (w)==64 ? 62 : 0)

`define LBIST_TAP4(w) ( \
    (w)==8  ?  7 : (w)==12 ? 11 : (w)==13 ? 12 : (w)==14 ? 13 : (w)==16 ? 15 : (w)==19 ? 18 : \
    (w)==24 ? 23 : (w)==26 ? 25 : (w)==27 ? 26 : (w)==30 ? 29 : (w)==32 ? 31 : (w)==34 ? 33 : \
    (w)==37 ? 36 : (w)==38 ? 37 : (w)==40 ? 39 : (w)==64 ? 63 : 0)

// ==============================
// Signature register
// ==============================
`define LBIST_SIG_BITS   17
`define LBIST_SIG_TAP_HI 16
`define LBIST_SIG_TAP_LO 13

`endif

//--- verilog/cut_pkg.sv
`include "lbist_macros.svh"

package cut_pkg;

    // Pattern from generator A
    typedef logic [`LBIST_A_BITS-1:0] operand_a_t;

    // Pattern from generator B
    typedef logic [`LBIST_B_BITS-1:0] operand_b_t;

    // Adder response, one extra bit for the carry out
    typedef logic [`LBIST_A_BITS:0] cut_resp_t;

endpackage

//--- verilog/lbist_pkg.sv
`include "lbist_macros.svh"

package lbist_pkg;

    // Test request, count of zero is not allowed
    typedef struct packed {
        logic [`LBIST_A_BITS-1:0]   seed_a;
        logic [`LBIST_B_BITS-1:0]   seed_b;
        logic [`LBIST_CNT_BITS-1:0] count;
    } lbist_req_t;

    // Final signature with the request count echoed back
    typedef struct packed {
        logic [`LBIST_SIG_BITS-1:0] signature;
        logic [`LBIST_CNT_BITS-1:0] count;
    } lbist_result_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        REPORT
    } ctrl_state_t;

endpackage

//--- verilog/lfsr_gen.sv
`timescale 1ns/1ps
`include "lbist_macros.svh"

module lfsr_gen
    import cut_pkg::*;
#(
    parameter type PAYLOAD_T = operand_a_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     seed_load,
    input  PAYLOAD_T seed,
    input  logic     gen_clear,
    input  logic     pattern_rdy,
    output logic     pattern_val,
    output PAYLOAD_T pattern
);

    localparam int WIDTH    = $bits(PAYLOAD_T);
    localparam int T1       = `LBIST_TAP1(WIDTH);
    localparam int T2       = `LBIST_TAP2(WIDTH);
    localparam int T3       = `LBIST_TAP3(WIDTH);
    localparam int T4       = `LBIST_TAP4(WIDTH);
    localparam bit FOUR_TAP = `LBIST_FOUR_TAP(WIDTH);

    typedef enum logic {
        GEN_IDLE,
        GEN_RUN
    } gen_state_t;

    gen_state_t state;
    gen_state_t next_state;
    PAYLOAD_T   q;
    PAYLOAD_T   q_next;
    logic       feedback;

    // ==============================
    // Feedback
    // ==============================
    generate
        if (!(`LBIST_WIDTH_OK(WIDTH))) begin : g_unsupported
            $fatal(1, "lfsr_gen: no tap entry for pattern width %0d", WIDTH);
        end

        if (FOUR_TAP) begin : g_four_tap
            assign feedback = ~(q[T1] ^ q[T2] ^ q[T3] ^ q[T4]);
        end else begin : g_two_tap
            assign feedback = q[T1] ^ q[T2];
        end
    endgenerate

    // Shift left, new bit enters at the bottom
    assign q_next = PAYLOAD_T'({q[WIDTH-2:0], feedback});

    // ==============================
    // Control
    // ==============================
    always_comb begin
        next_state = state;
        case (state)
            GEN_IDLE: if (seed_load) next_state = GEN_RUN;
            GEN_RUN:  if (gen_clear) next_state = GEN_IDLE;
            default:  next_state = GEN_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= GEN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Seed taken in idle, one step per accepted pattern
    always_ff @(posedge clk) begin
        if (state == GEN_IDLE && seed_load) begin
            q <= seed;
        end else if (state == GEN_RUN && pattern_rdy) begin
            q <= q_next;
        end
    end

    assign pattern_val = (state == GEN_RUN);
    assign pattern     = pattern_val ? q : '0;

endmodule

//--- verilog/cut_adder.sv
`timescale 1ns/1ps

module cut_adder
    import cut_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  operand_a_t a,
    input  operand_b_t b,
    input  logic       step,
    output logic       resp_val,
    output cut_resp_t  resp
);

    // One-cycle valid behind each step
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_val <= 1'b0;
        end else begin
            resp_val <= step;
        end
    end

    // Both operands zero-extended to the full response width
    always_ff @(posedge clk) begin
        if (step) begin
            resp <= cut_resp_t'(a) + cut_resp_t'(b);
        end
    end

endmodule

//--- verilog/lbist_ctrl.sv
`timescale 1ns/1ps
`include "lbist_macros.svh"

module lbist_ctrl
    import cut_pkg::*;
    import lbist_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  lbist_req_t    req,
    input  logic          req_val,
    output logic          req_rdy,
    output lbist_result_t result,
    output logic          result_val,
    input  logic          result_rdy,
    output logic          seed_load,
    output operand_a_t    seed_a,
    output operand_b_t    seed_b,
    output logic          gen_clear,
    output logic          pattern_rdy,
    input  logic          resp_val,
    input  cut_resp_t     resp
);

    localparam int CNT_W = `LBIST_CNT_BITS;
    localparam int SIG_W = `LBIST_SIG_BITS;

    ctrl_state_t      state;
    ctrl_state_t      next_state;
    logic [CNT_W-1:0] remaining;
    logic [CNT_W-1:0] count_q;
    logic [SIG_W-1:0] signature;
    logic [SIG_W-1:0] sig_next;
    logic             accept;
    logic             last_step;

    // ==============================
    // Handshakes
    // ==============================
    assign req_rdy     = (state == IDLE);
    assign accept      = req_val && req_rdy;
    assign result_val  = (state == REPORT);
    assign gen_clear   = result_val && result_rdy;
    assign pattern_rdy = (state == RUN);

    // Seeds go straight through, generators load on the accept edge
    assign seed_load = accept;
    assign seed_a    = req.seed_a;
    assign seed_b    = req.seed_b;

    // Remaining count of one or zero
    assign last_step = (remaining[CNT_W-1:1] == '0);

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (accept) next_state = RUN;
            RUN:     if (last_step) next_state = DRAIN;
            DRAIN:   if (resp_val) next_state = REPORT;
            REPORT:  if (result_rdy) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            remaining <= '0;
        end else begin
            state <= next_state;
            if (accept) begin
                remaining <= req.count;
            end else if (state == RUN) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // ==============================
    // Signature
    // ==============================
    // MISR step, shift with feedback then fold in the response
    assign sig_next = {signature[SIG_W-2:0],
                       signature[`LBIST_SIG_TAP_HI] ^ signature[`LBIST_SIG_TAP_LO]} ^ resp;

    always_ff @(posedge clk) begin
        if (accept) begin
            signature <= '0;
            count_q   <= req.count;
        end else if (resp_val) begin
            signature <= sig_next;
        end
    end

    // No responses arrive in REPORT so the result holds under back-pressure
    assign result = '{signature: signature, count: count_q};

endmodule

//--- verilog/lbist_top.sv
`timescale 1ns/1ps

module lbist_top
    import cut_pkg::*;
    import lbist_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  lbist_req_t    req,
    input  logic          req_val,
    output logic          req_rdy,
    output lbist_result_t result,
    output logic          result_val,
    input  logic          result_rdy
);

    logic       seed_load;
    logic       gen_clear;
    logic       pattern_rdy;
    operand_a_t seed_a;
    operand_b_t seed_b;
    operand_a_t pattern_a;
    operand_b_t pattern_b;
    logic       resp_val;
    cut_resp_t  resp;

    // ==============================
    // Pattern generators
    // ==============================
    // Both run in lockstep on the shared pattern_rdy
    // Controller only paces them after loading, so pattern_val stays local
    lfsr_gen #(
        .PAYLOAD_T (operand_a_t)
    ) gen_a (
        .clk         (clk),
        .reset       (reset),
        .seed_load   (seed_load),
        .seed        (seed_a),
        .gen_clear   (gen_clear),
        .pattern_rdy (pattern_rdy),
        .pattern_val (),
        .pattern     (pattern_a)
    );

    lfsr_gen #(
        .PAYLOAD_T (operand_b_t)
    ) gen_b (
        .clk         (clk),
        .reset       (reset),
        .seed_load   (seed_load),
        .seed        (seed_b),
        .gen_clear   (gen_clear),
        .pattern_rdy (pattern_rdy),
        .pattern_val (),
        .pattern     (pattern_b)
    );

    // ==============================
    // Circuit under test and control
    // ==============================
    cut_adder cut (
        .clk      (clk),
        .reset    (reset),
        .a        (pattern_a),
        .b        (pattern_b),
        .step     (pattern_rdy),
        .resp_val (resp_val),
        .resp     (resp)
    );

    lbist_ctrl ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .req_val     (req_val),
        .req_rdy     (req_rdy),
        .result      (result),
        .result_val  (result_val),
        .result_rdy  (result_rdy),
        .seed_load   (seed_load),
        .seed_a      (seed_a),
        .seed_b      (seed_b),
        .gen_clear   (gen_clear),
        .pattern_rdy (pattern_rdy),
        .resp_val    (resp_val),
        .resp        (resp)
    );

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

//--- tb/lbist_properties.sv
`timescale 1ns/1ps

module lbist_properties
    import lbist_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input logic          req_rdy,
    input logic          result_val,
    input logic          result_rdy,
    input logic          pattern_rdy,
    input lbist_result_t result
);

    // Failures seen, read by the testbench at the end
    int assert_fails = 0;

    // No new request while a result waits
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        !(req_rdy && result_val))
        else begin
            $error("req_rdy and result_val high in the same cycle");
            assert_fails++;
        end

    // Result held under back-pressure
    a_result_hold: assert property (@(posedge clk) disable iff (reset)
        result_val && !result_rdy |=> result_val && $stable(result))
        else begin
            $error("result changed or dropped before its transfer");
            assert_fails++;
        end

    a_reset_idle: assert property (@(posedge clk) reset |=> !pattern_rdy)
        else begin
            $error("pattern_rdy high in the cycle after reset");
            assert_fails++;
        end

endmodule

//--- tb/lbist_tb.sv
`timescale 1ns/1ps
`include "lbist_macros.svh"

module lbist_tb
    import cut_pkg::*;
    import lbist_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int N_TESTS    = 22;

    logic          clk;
    logic          reset;
    lbist_req_t    req;
    logic          req_val;
    logic          req_rdy;
    lbist_result_t result;
    logic          result_val;
    logic          result_rdy;

    lbist_req_t    tests [N_TESTS];
    int            stall_len [N_TESTS];
    lbist_result_t expect_q [$];
    time           accept_q [$];
    logic [15:0]   rng_state;
    longint        watchdog_ns = 0;
    int            result_errors;
    int            flag_errors;
    int            latency_errors;
    int            other_errors;
    int            results_done;
    logic          holding;
    lbist_result_t held;
    int            stall_left;

    tb_clkgen #(
        .PERIOD_NS (CLK_PERIOD)
    ) clkgen (
        .clk (clk)
    );

    lbist_top lbist_top_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_val    (req_val),
        .req_rdy    (req_rdy),
        .result     (result),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    bind lbist_ctrl lbist_properties props (
        .clk         (clk),
        .reset       (reset),
        .req_rdy     (req_rdy),
        .result_val  (result_val),
        .result_rdy  (result_rdy),
        .pattern_rdy (pattern_rdy),
        .result      (result)
    );

    // ==============================
    // Random source and reference model
    // ==============================
    // Galois form, polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | rng_state[0];
            rng_state = lfsr_step(rng_state);
        end
        return val;
    endfunction

    // Inverted XOR over taps 10, 12, 13, 15
    function automatic operand_a_t step_a(input operand_a_t q);
        logic fb;
        fb = ~(q[10] ^ q[12] ^ q[13] ^ q[15]);
        return {q[14:0], fb};
    endfunction

    // Inverted XOR over taps 3, 4, 5, 7
    function automatic operand_b_t step_b(input operand_b_t q);
        logic fb;
        fb = ~(q[3] ^ q[4] ^ q[5] ^ q[7]);
        return {q[6:0], fb};
    endfunction

    function automatic logic [`LBIST_SIG_BITS-1:0] expected_signature(input lbist_req_t r);
        operand_a_t                 a;
        operand_b_t                 b;
        cut_resp_t                  sum;
        logic [`LBIST_SIG_BITS-1:0] sig;
        a   = r.seed_a;
        b   = r.seed_b;
        sig = '0;
        for (int i = 0; i < r.count; i++) begin
            sum = {1'b0, a} + {9'b0, b};
            sig = {sig[15:0], sig[16] ^ sig[13]} ^ sum;
            a   = step_a(a);
            b   = step_b(b);
        end
        return sig;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_result(input string name, input lbist_result_t got,
                                input lbist_result_t exp);
        if (got !== exp) begin
            result_errors++;
            $display("ERROR %s: signature %h count %h, expected signature %h count %h",
                     name, got.signature, got.count, exp.signature, exp.count);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            latency_errors++;
            $display("ERROR %s: got %h cycles, expected %h", name, got, exp);
        end
    endtask

    // ==============================
    // Checker, also drives result_rdy
    // ==============================
    always @(negedge clk) begin
        if (!reset) begin
            // All-ones seeds lock both generators up
            if (results_done == 1 && lbist_top_i.pattern_rdy) begin
                check_bit("pattern_a all ones", &lbist_top_i.pattern_a, 1'b1);
                check_bit("pattern_b all ones", &lbist_top_i.pattern_b, 1'b1);
            end
            if (result_val) begin
                check_bit("req_rdy", req_rdy, 1'b0);
                if (!holding) begin
                    holding    = 1'b1;
                    held       = result;
                    stall_left = (results_done < N_TESTS) ? stall_len[results_done] : 0;
                    if (accept_q.size() > 0) begin
                        check_latency("result_val latency",
                                      int'(($time - accept_q.pop_front()) / CLK_PERIOD),
                                      expect_q[0].count + 2);
                    end else begin
                        other_errors++;
                        $display("A result came back with no request accepted");
                    end
                end else begin
                    check_result("result under back-pressure", result, held);
                end
                if (stall_left == 0) begin
                    result_rdy = 1'b1;
                    if (expect_q.size() > 0) begin
                        check_result("result", result, expect_q.pop_front());
                    end
                    holding = 1'b0;
                    results_done++;
                end else begin
                    result_rdy = 1'b0;
                    stall_left--;
                end
            end else begin
                result_rdy = 1'b0;
            end
        end
    end

    // Watchdog, armed once the test lengths are known
    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Run timed out after %0d ns with %0d of %0d results returned",
                 watchdog_ns, results_done, N_TESTS);
        $display("TB FAILED");
        $finish;
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        longint total;
        int     all_errors;
        reset          = 1'b1;
        req            = '0;
        req_val        = 1'b0;
        result_rdy     = 1'b0;
        rng_state      = 16'd37904;
        result_errors  = 0;
        flag_errors    = 0;
        latency_errors = 0;
        other_errors   = 0;
        results_done   = 0;
        holding        = 1'b0;
        stall_left     = 0;

        // Directed tests first
        tests[0] = '{seed_a: 16'h1D2B, seed_b: 8'h6E, count: 10'd1};
        tests[1] = '{seed_a: '1, seed_b: '1, count: 10'd8};
        for (int i = 2; i < N_TESTS; i++) begin
            tests[i].seed_a = operand_a_t'(take_bits(16));
            tests[i].seed_b = operand_b_t'(take_bits(8));
            tests[i].count  = 10'(1 + take_bits(9) % 300);
        end
        total = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            stall_len[i] = take_bits(2);
            total += tests[i].count + 10;
        end
        watchdog_ns = (total + 100) * CLK_PERIOD;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit("req_rdy after reset", req_rdy, 1'b1);
        check_bit("result_val after reset", result_val, 1'b0);

        // Next request waits with req_val high while the last result is out
        for (int i = 0; i < N_TESTS; i++) begin
            req     = tests[i];
            req_val = 1'b1;
            while (!req_rdy) @(negedge clk);
            expect_q.push_back('{signature: expected_signature(tests[i]),
                                 count: tests[i].count});
            accept_q.push_back($time);
            @(negedge clk);
        end
        req_val = 1'b0;

        while (results_done < N_TESTS) @(negedge clk);
        repeat (2) @(negedge clk);

        all_errors = result_errors + flag_errors + latency_errors + other_errors
                   + lbist_top_i.ctrl.props.assert_fails;
        $display("Errors: result %0d, flag %0d, latency %0d, other %0d, assertion %0d",
                 result_errors, flag_errors, latency_errors, other_errors,
                 lbist_top_i.ctrl.props.assert_fails);
        if (all_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verilog
verilog/cut_pkg.sv
verilog/lbist_pkg.sv
verilog/lfsr_gen.sv
verilog/cut_adder.sv
verilog/lbist_ctrl.sv
verilog/lbist_top.sv
tb/tb_clkgen.sv
tb/lbist_properties.sv
tb/lbist_tb.sv

//--- Bender.yml
package:
  name: lbist

export_include_dirs:
  - verilog

sources:
  # RTL, packages first
  - files:
      - verilog/cut_pkg.sv
      - verilog/lbist_pkg.sv
      - verilog/lfsr_gen.sv
      - verilog/cut_adder.sv
      - verilog/lbist_ctrl.sv
      - verilog/lbist_top.sv

  # Testbench, top module lbist_tb
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/lbist_properties.sv
      - tb/lbist_tb.sv
